// File: cabletest.f
src/cabletest_pkg.sv
src/cabletest_config.sv
src/cabletest_stats.sv
src/cabletest_readback.sv
src/cabletest_reset_seq.sv
src/cabletest_ctl.sv
tests/cabletest_tb.sv

// File: src/cabletest_config.sv
// Cable tester write decoder
// Holds the test configuration and turns register writes into one-cycle control pulses

`timescale 1ns/1ps

module cabletest_config import cabletest_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    // Write strobe from the host
    input  logic               reg_write,
    input  logic [INDX_W-1:0]  reg_windx,
    input  logic [DATA_W-1:0]  reg_wdata,
    output logic [1:0]         reg_wresp,
    // Busy bits of both lanes
    input  logic [1:0]         busy,
    // Test configuration
    output logic [CPP_W-1:0]   cycles_per_packet,
    output logic [COUNT_W-1:0] packet_count,
    output logic [DATA_W-1:0]  bytes_per_usec,
    output logic               rsfec_enable,
    output logic [TXPRE_W-1:0] cmac_txpre,
    // One-cycle control pulses
    output logic               start,
    output logic               halt,
    output logic               inject1,
    output logic               inject2,
    output logic               perform_reset
);

    // Same write word, decoded as raw data and as control fields
    ctl_word_u wword;

    // Both generators idle
    logic lanes_idle;

    // Full packet count if the low half were taken from this write
    logic [COUNT_W-1:0] count_next;

    assign wword      = reg_wdata;
    assign lanes_idle = (busy == 2'b00);
    assign count_next = {packet_count[COUNT_W-1:DATA_W], wword.raw};

    // ==============================
    // Write decode
    // ==============================
    always_ff @(posedge clk) begin
        // Pulses last one cycle only
        start         <= 1'b0;
        halt          <= 1'b0;
        inject1       <= 1'b0;
        inject2       <= 1'b0;
        perform_reset <= 1'b0;

        if (!resetn) begin
            reg_wresp         <= RESP_OKAY;
            cycles_per_packet <= CPP_W'(DEFAULT_CYCLES_PER_PACKET);
            packet_count      <= '0;
            bytes_per_usec    <= DATA_W'(DEFAULT_BYTES_PER_USEC);
            rsfec_enable      <= 1'(DEFAULT_RSFEC);
            cmac_txpre        <= TXPRE_W'(DEFAULT_TXPRE);
        end else if (reg_write) begin
            // Every known index answers OKAY, even when the write is gated off
            reg_wresp <= RESP_OKAY;

            case (reg_windx)
                // Test shape is frozen while a lane is running
                REG_CYCLES_PER_PACKET: begin
                    if (lanes_idle) begin
                        cycles_per_packet <= wword.raw[CPP_W-1:0];
                    end
                end
                REG_PACKET_COUNTH: begin
                    if (lanes_idle) begin
                        packet_count[COUNT_W-1:DATA_W] <= wword.raw;
                    end
                end
                // Low half commits the count and launches the test
                REG_PACKET_COUNTL: begin
                    if (lanes_idle) begin
                        packet_count[DATA_W-1:0] <= wword.raw;
                        start                    <= (count_next != '0);
                    end
                end
                REG_CONTROL: begin
                    inject1 <= wword.fields.inject1;
                    inject2 <= wword.fields.inject2;
                    halt    <= wword.fields.halt;
                end
                REG_BYTES_PER_USEC: bytes_per_usec <= wword.raw;
                REG_RESET:          perform_reset  <= 1'b1;
                REG_RSFEC:          rsfec_enable   <= wword.raw[0];
                REG_TXPRE:          cmac_txpre     <= wword.raw[TXPRE_W-1:0];
                // Read-only and unmapped indices
                default:            reg_wresp      <= RESP_DECERR;
            endcase
        end
    end

    // Start never reaches a lane that is busy
    assert property (@(posedge clk) disable iff (!resetn)
        start |-> busy == 2'b00);

endmodule

// File: src/cabletest_ctl.sv
// Cable tester control block
// Register file for a two-lane tester, with generator control, lane statistics and reset output

`timescale 1ns/1ps

module cabletest_ctl import cabletest_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    // Register write port
    input  logic               reg_write,
    input  logic [INDX_W-1:0]  reg_windx,
    input  logic [DATA_W-1:0]  reg_wdata,
    output logic [1:0]         reg_wresp,
    // Register read port
    input  logic               reg_read,
    input  logic [INDX_W-1:0]  reg_rindx,
    output logic [DATA_W-1:0]  reg_rdata,
    output logic [1:0]         reg_rresp,
    // PCS alignment of both links
    input  logic               eth0_up,
    input  logic               eth1_up,
    // Packet generators and receivers
    input  logic [2:0]         pg_status_1,
    input  logic [2:0]         pg_status_2,
    input  logic [1:0]         pr_status_1,
    input  logic [1:0]         pr_status_2,
    output logic [2:0]         pg_control_1,
    output logic [2:0]         pg_control_2,
    // Test configuration
    output logic [CPP_W-1:0]   cycles_per_packet,
    output logic [COUNT_W-1:0] packet_count,
    output logic [DATA_W-1:0]  bytes_per_usec,
    output logic               rsfec_enable,
    output logic [TXPRE_W-1:0] cmac_txpre,
    // Reset for the rest of the tester
    output logic               resetn_out
);

    logic start, halt, inject1, inject2, perform_reset;
    logic [1:0] busy, halted;
    logic [COUNT_W-1:0] packets_out1, packets_out2, packets_in1, packets_in2;
    logic [ERR_W-1:0] errors1, errors2;

    // ==============================
    // Generator control and status
    // ==============================
    // Start and halt go to both lanes, inject is per lane
    assign pg_control_1[CTL_START]  = start;
    assign pg_control_1[CTL_HALT]   = halt;
    assign pg_control_1[CTL_INJECT] = inject1;
    assign pg_control_2[CTL_START]  = start;
    assign pg_control_2[CTL_HALT]   = halt;
    assign pg_control_2[CTL_INJECT] = inject2;

    assign busy   = {pg_status_2[STA_BUSY], pg_status_1[STA_BUSY]};
    assign halted = {pg_status_2[STA_HALTED], pg_status_1[STA_HALTED]};

    cabletest_config u_config (
        .clk(clk), .resetn(resetn),
        .reg_write(reg_write), .reg_windx(reg_windx), .reg_wdata(reg_wdata),
        .reg_wresp(reg_wresp), .busy(busy),
        .cycles_per_packet(cycles_per_packet), .packet_count(packet_count),
        .bytes_per_usec(bytes_per_usec), .rsfec_enable(rsfec_enable),
        .cmac_txpre(cmac_txpre),
        .start(start), .halt(halt), .inject1(inject1), .inject2(inject2),
        .perform_reset(perform_reset)
    );

    cabletest_stats u_stats (
        .clk(clk), .resetn(resetn), .start(start),
        .pg_status_1(pg_status_1), .pg_status_2(pg_status_2),
        .pr_status_1(pr_status_1), .pr_status_2(pr_status_2),
        .packets_out1(packets_out1), .packets_out2(packets_out2),
        .packets_in1(packets_in1), .packets_in2(packets_in2),
        .errors1(errors1), .errors2(errors2)
    );

    cabletest_readback u_readback (
        .clk(clk), .resetn(resetn),
        .reg_read(reg_read), .reg_rindx(reg_rindx),
        .reg_rdata(reg_rdata), .reg_rresp(reg_rresp),
        .packets_out1(packets_out1), .packets_out2(packets_out2),
        .packets_in1(packets_in1), .packets_in2(packets_in2),
        .errors1(errors1), .errors2(errors2),
        .cycles_per_packet(cycles_per_packet), .packet_count(packet_count),
        .bytes_per_usec(bytes_per_usec), .rsfec_enable(rsfec_enable),
        .cmac_txpre(cmac_txpre),
        .busy(busy), .halted(halted), .eth0_up(eth0_up), .eth1_up(eth1_up),
        .resetn_out(resetn_out)
    );

    cabletest_reset_seq u_reset_seq (
        .clk(clk), .resetn(resetn),
        .perform_reset(perform_reset), .resetn_out(resetn_out)
    );

endmodule

// File: src/cabletest_pkg.sv
// Cable tester control package
// Register map, field widths, status bit positions and reset timing shared by the control block

package cabletest_pkg;

    // ==============================
    // Register port
    // ==============================
    localparam int DATA_W = 32;
    localparam int INDX_W = 32;

    // Register indices, in map order
    localparam int REG_MODULE_REV        = 0;
    localparam int REG_STATUS            = 1;
    localparam int REG_CYCLES_PER_PACKET = 2;
    localparam int REG_PACKET_COUNTH     = 3;
    localparam int REG_PACKET_COUNTL     = 4;
    localparam int REG_PACKETS_SENT1H    = 5;
    localparam int REG_PACKETS_SENT1L    = 6;
    localparam int REG_PACKETS_SENT2H    = 7;
    localparam int REG_PACKETS_SENT2L    = 8;
    localparam int REG_PACKETS_RCVD1H    = 9;
    localparam int REG_PACKETS_RCVD1L    = 10;
    localparam int REG_PACKETS_RCVD2H    = 11;
    localparam int REG_PACKETS_RCVD2L    = 12;
    localparam int REG_ERRORS1           = 13;
    localparam int REG_ERRORS2           = 14;
    localparam int REG_CONTROL           = 15;
    localparam int REG_ETH_STATUS        = 16;
    localparam int REG_BYTES_PER_USEC    = 17;
    localparam int REG_RESET             = 18;
    localparam int REG_RSFEC             = 19;
    localparam int REG_TXPRE             = 20;

    // Bumped whenever the register map changes
    localparam int MODULE_VERSION = 1;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // Field widths
    localparam int CPP_W   = 8;
    localparam int COUNT_W = 64;
    localparam int ERR_W   = 32;
    localparam int TXPRE_W = 5;

    // Values loaded by reset
    localparam int DEFAULT_CYCLES_PER_PACKET = 16;
    localparam int DEFAULT_BYTES_PER_USEC    = 11000;
    localparam int DEFAULT_TXPRE             = 0;
    localparam int DEFAULT_RSFEC             = 1;

    // ==============================
    // Generator and receiver bits
    // ==============================
    // pg_control word
    localparam int CTL_START  = 0;
    localparam int CTL_HALT   = 1;
    localparam int CTL_INJECT = 2;
    // pg_status word
    localparam int STA_BUSY   = 0;
    localparam int STA_SENT   = 1;
    localparam int STA_HALTED = 2;
    // pr_status word
    localparam int STA_RCVD   = 0;
    localparam int STA_ERROR  = 1;

    // ==============================
    // Reset sequencing
    // ==============================
    localparam int CLK_MHZ       = 125;
    localparam int RESET_USECS   = 1;
    localparam int RESET_CYCLES  = CLK_MHZ * RESET_USECS;
    localparam int RESET_TIMER_W = $clog2(RESET_CYCLES + 1);

    // Sequencer states
    localparam logic [1:0] RS_LOAD = 2'd0;
    localparam logic [1:0] RS_HOLD = 2'd1;
    localparam logic [1:0] RS_RUN  = 2'd2;

    // Write word seen as raw data or as REG_CONTROL fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [DATA_W-4:0] reserved;
            logic              halt;
            logic              inject2;
            logic              inject1;
        } fields;
    } ctl_word_u;

endpackage

// File: src/cabletest_readback.sv
// Cable tester readback multiplexer
// Registers the word selected by each read index, with a decode response

`timescale 1ns/1ps

module cabletest_readback import cabletest_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    // Read strobe from the host
    input  logic               reg_read,
    input  logic [INDX_W-1:0]  reg_rindx,
    output logic [DATA_W-1:0]  reg_rdata,
    output logic [1:0]         reg_rresp,
    // Lane counters
    input  logic [COUNT_W-1:0] packets_out1,
    input  logic [COUNT_W-1:0] packets_out2,
    input  logic [COUNT_W-1:0] packets_in1,
    input  logic [COUNT_W-1:0] packets_in2,
    input  logic [ERR_W-1:0]   errors1,
    input  logic [ERR_W-1:0]   errors2,
    // Test configuration
    input  logic [CPP_W-1:0]   cycles_per_packet,
    input  logic [COUNT_W-1:0] packet_count,
    input  logic [DATA_W-1:0]  bytes_per_usec,
    input  logic               rsfec_enable,
    input  logic [TXPRE_W-1:0] cmac_txpre,
    // Generator and link status
    input  logic [1:0]         busy,
    input  logic [1:0]         halted,
    input  logic               eth0_up,
    input  logic               eth1_up,
    input  logic               resetn_out
);

    // Halted pair above busy pair
    logic [DATA_W-1:0] status_word;
    // One link per half word
    logic [DATA_W-1:0] eth_word;

    assign status_word = DATA_W'({halted, busy});
    assign eth_word    = {15'b0, eth1_up, 15'b0, eth0_up};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_rresp <= RESP_OKAY;
        end else if (reg_read) begin
            reg_rresp <= RESP_OKAY;
            case (reg_rindx)
                REG_MODULE_REV:        reg_rdata <= DATA_W'(MODULE_VERSION);
                REG_STATUS:            reg_rdata <= status_word;
                REG_CYCLES_PER_PACKET: reg_rdata <= DATA_W'(cycles_per_packet);
                REG_PACKET_COUNTH:     reg_rdata <= packet_count[COUNT_W-1:DATA_W];
                REG_PACKET_COUNTL:     reg_rdata <= packet_count[DATA_W-1:0];
                REG_PACKETS_SENT1H:    reg_rdata <= packets_out1[COUNT_W-1:DATA_W];
                REG_PACKETS_SENT1L:    reg_rdata <= packets_out1[DATA_W-1:0];
                REG_PACKETS_SENT2H:    reg_rdata <= packets_out2[COUNT_W-1:DATA_W];
                REG_PACKETS_SENT2L:    reg_rdata <= packets_out2[DATA_W-1:0];
                REG_PACKETS_RCVD1H:    reg_rdata <= packets_in1[COUNT_W-1:DATA_W];
                REG_PACKETS_RCVD1L:    reg_rdata <= packets_in1[DATA_W-1:0];
                REG_PACKETS_RCVD2H:    reg_rdata <= packets_in2[COUNT_W-1:DATA_W];
                REG_PACKETS_RCVD2L:    reg_rdata <= packets_in2[DATA_W-1:0];
                REG_ERRORS1:           reg_rdata <= DATA_W'(errors1);
                REG_ERRORS2:           reg_rdata <= DATA_W'(errors2);
                REG_ETH_STATUS:        reg_rdata <= eth_word;
                REG_BYTES_PER_USEC:    reg_rdata <= bytes_per_usec;
                // Reads 1 while the reset sequence is running
                REG_RESET:             reg_rdata <= DATA_W'(!resetn_out);
                REG_RSFEC:             reg_rdata <= DATA_W'(rsfec_enable);
                REG_TXPRE:             reg_rdata <= DATA_W'(cmac_txpre);
                // REG_CONTROL is write-only, like any unmapped index
                default: begin
                    reg_rdata <= '0;
                    reg_rresp <= RESP_DECERR;
                end
            endcase
        end
    end

    // Every read answers OKAY or DECERR
    assert property (@(posedge clk) disable iff (!resetn)
        reg_read |=> reg_rresp != RESP_SLVERR);

endmodule

// File: src/cabletest_reset_seq.sv
// Cable tester reset sequencer
// Holds resetn_out low for a fixed time after power-up and on each reset request

`timescale 1ns/1ps

module cabletest_reset_seq import cabletest_pkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic perform_reset,
    output logic resetn_out
);

    logic [1:0]               state;
    logic [RESET_TIMER_W-1:0] timer;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= RS_LOAD;
            timer      <= '0;
            resetn_out <= 1'b0;
        end else begin
            // Free-running countdown, a load takes priority
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end

            case (state)
                // First cycle out of system reset
                RS_LOAD: begin
                    resetn_out <= 1'b0;
                    timer      <= RESET_TIMER_W'(RESET_CYCLES);
                    state      <= RS_HOLD;
                end
                // Release once the timer has run out
                RS_HOLD: begin
                    if (timer == '0) begin
                        resetn_out <= 1'b1;
                        state      <= RS_RUN;
                    end
                end
                // Running, wait for a host request
                RS_RUN: begin
                    if (perform_reset) begin
                        resetn_out <= 1'b0;
                        timer      <= RESET_TIMER_W'(RESET_CYCLES);
                        state      <= RS_HOLD;
                    end
                end
                default: state <= RS_LOAD;
            endcase
        end
    end

    // Output stays asserted for the whole countdown
    assert property (@(posedge clk) disable iff (!resetn)
        (timer != '0) |-> !resetn_out);

endmodule

// File: src/cabletest_stats.sv
// Cable tester statistics
// Counts sent packets, received packets and mismatch errors per lane, cleared on start

`timescale 1ns/1ps

module cabletest_stats import cabletest_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    // Event pulses from the generators and receivers
    input  logic [2:0]         pg_status_1,
    input  logic [2:0]         pg_status_2,
    input  logic [1:0]         pr_status_1,
    input  logic [1:0]         pr_status_2,
    // Lane counters
    output logic [COUNT_W-1:0] packets_out1,
    output logic [COUNT_W-1:0] packets_out2,
    output logic [COUNT_W-1:0] packets_in1,
    output logic [COUNT_W-1:0] packets_in2,
    output logic [ERR_W-1:0]   errors1,
    output logic [ERR_W-1:0]   errors2
);

    // Clearing wins over a pulse in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn || start) begin
            packets_out1 <= '0;
            packets_out2 <= '0;
            packets_in1  <= '0;
            packets_in2  <= '0;
            errors1      <= '0;
            errors2      <= '0;
        end else begin
            if (pg_status_1[STA_SENT])  packets_out1 <= packets_out1 + 1'b1;
            if (pg_status_2[STA_SENT])  packets_out2 <= packets_out2 + 1'b1;
            if (pr_status_1[STA_RCVD])  packets_in1  <= packets_in1 + 1'b1;
            if (pr_status_2[STA_RCVD])  packets_in2  <= packets_in2 + 1'b1;
            if (pr_status_1[STA_ERROR]) errors1      <= errors1 + 1'b1;
            if (pr_status_2[STA_ERROR]) errors2      <= errors2 + 1'b1;
        end
    end

    // ==============================
    // Monotonic counters
    // ==============================
    // Only a clear may move a counter backwards
    property p_no_decrease(logic [COUNT_W-1:0] cnt);
        @(posedge clk) disable iff (!resetn)
            ($past(resetn) && !$past(start)) |-> cnt >= $past(cnt);
    endproperty

    assert property (p_no_decrease(packets_out1));
    assert property (p_no_decrease(packets_out2));
    assert property (p_no_decrease(packets_in1));
    assert property (p_no_decrease(packets_in2));
    assert property (p_no_decrease(COUNT_W'(errors1)));
    assert property (p_no_decrease(COUNT_W'(errors2)));

endmodule

// File: tests/cabletest_stim.txt
# Ops: W idx data resp | R idx data resp | E lane sent rcvd err | B busy halted | L eth0 eth1
# C inject1 inject2 halt | T waits for resetn_out; idx, counts, resp decimal and data hex
T
R 0 00000001 0
R 2 00000010 0
R 4 00000000 0
R 17 00002af8 0
R 18 00000000 0
R 19 00000001 0
R 20 00000000 0
# Configuration writes, masked to field width
W 2 00000123 0
R 2 00000023 0
W 20 000000ff 0
R 20 0000001f 0
W 17 00001234 0
R 17 00001234 0
W 19 00000000 0
R 19 00000000 0
# Unknown and read-only indices
W 30 deadbeef 3
R 30 00000000 3
R 15 00000000 3
W 0 00000005 3
R 0 00000001 0
# Lane statistics
E 1 3 2 1
E 2 5 4 2
R 5 00000000 0
R 6 00000003 0
R 8 00000005 0
R 10 00000002 0
R 12 00000004 0
R 13 00000001 0
R 14 00000002 0
# Zero count gives no start, a nonzero count starts and clears
W 3 00000000 0
W 4 00000000 0
R 8 00000005 0
W 4 00000007 0
R 4 00000007 0
R 6 00000000 0
R 8 00000000 0
R 12 00000000 0
R 14 00000000 0
# Busy lanes freeze the test shape
B 1 0
W 2 00000044 0
W 4 00000009 0
R 2 00000023 0
R 4 00000007 0
R 1 00000001 0
B 2 3
R 1 0000000e 0
B 0 0
# Link status
L 1 1
R 16 00010001 0
L 0 1
R 16 00010000 0
# Halt and inject
C 1 0 1
C 0 1 0
# Reset request
W 18 00000001 0
R 18 00000001 0
T
R 18 00000000 0

// File: tests/cabletest_tb.sv
// Cable tester control block testbench
// Replays the stimulus file on the register port and checks responses, pulses and reset output

`timescale 1ns/1ps

module cabletest_tb import cabletest_pkg::*; ();

    // Longest wait for resetn_out, in clock cycles
    localparam int WAIT_LIMIT = 4 * RESET_CYCLES;

    logic               clk;
    logic               resetn;
    logic               reg_write;
    logic [INDX_W-1:0]  reg_windx;
    logic [DATA_W-1:0]  reg_wdata;
    logic [1:0]         reg_wresp;
    logic               reg_read;
    logic [INDX_W-1:0]  reg_rindx;
    logic [DATA_W-1:0]  reg_rdata;
    logic [1:0]         reg_rresp;
    logic               eth0_up;
    logic               eth1_up;
    logic [2:0]         pg_status_1;
    logic [2:0]         pg_status_2;
    logic [1:0]         pr_status_1;
    logic [1:0]         pr_status_2;
    logic [2:0]         pg_control_1;
    logic [2:0]         pg_control_2;
    logic [CPP_W-1:0]   cycles_per_packet;
    logic [COUNT_W-1:0] packet_count;
    logic [DATA_W-1:0]  bytes_per_usec;
    logic               rsfec_enable;
    logic [TXPRE_W-1:0] cmac_txpre;
    logic               resetn_out;

    // Tallies
    int checks = 0;
    int mismatches = 0;
    int failures = 0;
    bit aborted = 0;

    // Lane levels set by B operations
    logic [1:0] busy_mask = 2'b00;
    logic [1:0] halted_mask = 2'b00;
    // High half of the packet count as the host last committed it
    logic [DATA_W-1:0] counth_model = '0;

    // Start pulses expected and seen on each lane
    int exp_starts = 0;
    int seen_starts1 = 0;
    int seen_starts2 = 0;

    cabletest_ctl dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Start pulse monitor
    always @(posedge clk) begin
        if (resetn && pg_control_1[CTL_START]) seen_starts1 = seen_starts1 + 1;
        if (resetn && pg_control_2[CTL_START]) seen_starts2 = seen_starts2 + 1;
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Fail t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Fail t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Fail t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            mismatches++;
            $display("Fail t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ==============================
    // Bus and lane drivers
    // ==============================
    // All driving happens 1 ns after a rising edge
    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_lanes(input int lane, input logic sent, input logic rcvd,
                               input logic err);
        logic [2:0] pg1;
        logic [2:0] pg2;
        logic [1:0] pr1;
        logic [1:0] pr2;
        pg1 = '0;
        pg2 = '0;
        pr1 = '0;
        pr2 = '0;
        pg1[STA_BUSY]   = busy_mask[0];
        pg1[STA_HALTED] = halted_mask[0];
        pg2[STA_BUSY]   = busy_mask[1];
        pg2[STA_HALTED] = halted_mask[1];
        if (lane == 1) begin
            pg1[STA_SENT] = sent;
            pr1[STA_RCVD] = rcvd;
            pr1[STA_ERROR] = err;
        end else if (lane == 2) begin
            pg2[STA_SENT] = sent;
            pr2[STA_RCVD] = rcvd;
            pr2[STA_ERROR] = err;
        end
        pg_status_1 = pg1;
        pg_status_2 = pg2;
        pr_status_1 = pr1;
        pr_status_2 = pr2;
    endtask

    // Event pulses, one per cycle until each count is used up
    task automatic pulse_events(input int lane, input int nsent, input int nrcvd, input int nerr);
        int n;
        n = nsent;
        if (nrcvd > n) n = nrcvd;
        if (nerr > n) n = nerr;
        for (int i = 0; i < n; i++) begin
            drive_lanes(lane, i < nsent, i < nrcvd, i < nerr);
            next_edge();
        end
        drive_lanes(0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic write_reg(input logic [INDX_W-1:0] idx, input logic [DATA_W-1:0] data,
                             input logic [1:0] exp_resp);
        ctl_word_u  cw;
        logic       idle;
        logic [2:0] exp1;
        logic [2:0] exp2;
        cw.raw = data;
        idle = (busy_mask == 2'b00);
        exp1 = '0;
        exp2 = '0;
        // Start needs idle lanes and a nonzero 64-bit count
        exp1[CTL_START] = (idx == REG_PACKET_COUNTL) && idle && ({counth_model, data} != '0);
        exp2[CTL_START] = exp1[CTL_START];
        if (idx == REG_CONTROL) begin
            exp1[CTL_HALT]   = cw.fields.halt;
            exp1[CTL_INJECT] = cw.fields.inject1;
            exp2[CTL_HALT]   = cw.fields.halt;
            exp2[CTL_INJECT] = cw.fields.inject2;
        end
        if (idx == REG_PACKET_COUNTH && idle) counth_model = data;
        if (exp1[CTL_START]) exp_starts++;
        reg_write = 1'b1;
        reg_windx = idx;
        reg_wdata = data;
        next_edge();
        reg_write = 1'b0;
        check_resp("reg_wresp", reg_wresp, exp_resp);
        for (int b = 0; b < 3; b++) begin
            check_bit($sformatf("pg_control_1[%0d]", b), pg_control_1[b], exp1[b]);
            check_bit($sformatf("pg_control_2[%0d]", b), pg_control_2[b], exp2[b]);
        end
        // Pulses last a single cycle
        next_edge();
        check_bit("pg_control_1 after pulse", |pg_control_1, 1'b0);
        check_bit("pg_control_2 after pulse", |pg_control_2, 1'b0);
        if (idx == REG_RESET) check_bit("resetn_out", resetn_out, 1'b0);
    endtask

    task automatic read_reg(input logic [INDX_W-1:0] idx, input logic [DATA_W-1:0] exp_data,
                            input logic [1:0] exp_resp);
        reg_read  = 1'b1;
        reg_rindx = idx;
        next_edge();
        reg_read = 1'b0;
        check_word($sformatf("reg_rdata[idx %0d]", idx), reg_rdata, exp_data);
        check_resp($sformatf("reg_rresp[idx %0d]", idx), reg_rresp, exp_resp);
        // Configuration ports carry the same values as their registers
        case (idx)
            REG_CYCLES_PER_PACKET: begin
                check_word("cycles_per_packet", DATA_W'(cycles_per_packet), exp_data);
            end
            REG_PACKET_COUNTH: begin
                check_word("packet_count[63:32]", packet_count[COUNT_W-1:DATA_W], exp_data);
            end
            REG_PACKET_COUNTL: begin
                check_word("packet_count[31:0]", packet_count[DATA_W-1:0], exp_data);
            end
            REG_BYTES_PER_USEC: check_word("bytes_per_usec", bytes_per_usec, exp_data);
            REG_RSFEC:          check_bit("rsfec_enable", rsfec_enable, exp_data[0]);
            REG_TXPRE:          check_word("cmac_txpre", DATA_W'(cmac_txpre), exp_data);
            default: ;
        endcase
    endtask

    task automatic wait_resetn_out();
        int cycles;
        cycles = 0;
        while (resetn_out !== 1'b1 && cycles < WAIT_LIMIT) begin
            next_edge();
            cycles++;
        end
        if (resetn_out !== 1'b1) begin
            failures++;
            aborted = 1;
            $display("Timeout at t=%0t: resetn_out still low after %0d cycles", $time, cycles);
        end
    endtask

    // ==============================
    // Stimulus replay
    // ==============================
    initial begin
        int fd;
        int code;
        int a;
        int c;
        int d;
        int e;
        logic [DATA_W-1:0] data;
        logic [8*8-1:0]    op;
        logic [8*160-1:0]  line;
        bit done;
        bit bad_line;

        resetn    = 1'b0;
        reg_write = 1'b0;
        reg_windx = '0;
        reg_wdata = '0;
        reg_read  = 1'b0;
        reg_rindx = '0;
        eth0_up   = 1'b0;
        eth1_up   = 1'b0;
        drive_lanes(0, 1'b0, 1'b0, 1'b0);

        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;

        fd = $fopen("tests/cabletest_stim.txt", "r");
        done = (fd == 0);
        if (fd == 0) begin
            failures++;
            $display("Cannot open the stimulus file tests/cabletest_stim.txt");
        end

        while (!done) begin
            bad_line = 0;
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1;
            end else begin
                case (op)
                    "#": code = $fgets(line, fd);
                    "W": begin
                        code = $fscanf(fd, "%d %h %d", a, data, d);
                        if (code != 3) bad_line = 1;
                        else write_reg(a, data, d[1:0]);
                    end
                    "R": begin
                        code = $fscanf(fd, "%d %h %d", a, data, d);
                        if (code != 3) bad_line = 1;
                        else read_reg(a, data, d[1:0]);
                    end
                    "E": begin
                        code = $fscanf(fd, "%d %d %d %d", a, c, d, e);
                        if (code != 4) bad_line = 1;
                        else pulse_events(a, c, d, e);
                    end
                    "B": begin
                        code = $fscanf(fd, "%d %d", a, c);
                        if (code != 2) bad_line = 1;
                        busy_mask   = a[1:0];
                        halted_mask = c[1:0];
                        drive_lanes(0, 1'b0, 1'b0, 1'b0);
                    end
                    "L": begin
                        code = $fscanf(fd, "%d %d", a, c);
                        if (code != 2) bad_line = 1;
                        eth0_up = a[0];
                        eth1_up = c[0];
                    end
                    "C": begin
                        code = $fscanf(fd, "%d %d %d", a, c, d);
                        if (code != 3) begin
                            bad_line = 1;
                        end else begin
                            write_reg(REG_CONTROL, ctl_word_from(a[0], c[0], d[0]), RESP_OKAY);
                        end
                    end
                    "T": wait_resetn_out();
                    default: bad_line = 1;
                endcase
                if (bad_line) begin
                    failures++;
                    aborted = 1;
                    $display("Stimulus file has a line that cannot be parsed near op %s", op);
                end
                if (aborted) done = 1;
            end
        end
        if (fd != 0) $fclose(fd);

        check_count("start pulses on pg_control_1", seen_starts1, exp_starts);
        check_count("start pulses on pg_control_2", seen_starts2, exp_starts);

        $display("%0d checks, %0d mismatches, %0d other failures", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && checks > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // REG_CONTROL word assembled through the control-field view
    function automatic logic [DATA_W-1:0] ctl_word_from(input logic inj1, input logic inj2,
                                                       input logic hlt);
        ctl_word_u cw;
        cw.raw            = '0;
        cw.fields.inject1 = inj1;
        cw.fields.inject2 = inj2;
        cw.fields.halt    = hlt;
        return cw.raw;
    endfunction

endmodule
